//--- design/rv_settings.svh
`ifndef RV_SETTINGS_SVH
`define RV_SETTINGS_SVH

`default_nettype none

// data path and pc width
`define RV_XLEN 32

// architectural register file
`define RV_NUM_REGS 32
`define RV_REG_ADDR_W 5

// every instruction is one 32-bit word
`define RV_INSN_BYTES 4

// fetch address after reset
`define RV_RESET_PC 32'h0000_0000

`default_nettype wire

`endif

//--- design/rv_pkg.sv
`default_nettype none

package rv_pkg;

  // major opcodes, insn[6:0]
  // the unsupported ones are listed so the decoder can name them
  typedef enum logic [6:0] {
    OPC_LUI      = 7'b0110111,
    OPC_OP_IMM   = 7'b0010011,
    OPC_OP       = 7'b0110011,
    OPC_BRANCH   = 7'b1100011,
    OPC_SYSTEM   = 7'b1110011,
    OPC_LOAD     = 7'b0000011,
    OPC_STORE    = 7'b0100011,
    OPC_AUIPC    = 7'b0010111,
    OPC_JAL      = 7'b1101111,
    OPC_JALR     = 7'b1100111,
    OPC_MISC_MEM = 7'b0001111
  } opcode_e;

  // alu operations
  typedef enum logic [3:0] {
    ALU_ADD    = 4'd0,
    ALU_SUB    = 4'd1,
    ALU_SLL    = 4'd2,
    ALU_SLT    = 4'd3,
    ALU_SLTU   = 4'd4,
    ALU_XOR    = 4'd5,
    ALU_SRL    = 4'd6,
    ALU_SRA    = 4'd7,
    ALU_OR     = 4'd8,
    ALU_AND    = 4'd9,
    ALU_PASS_B = 4'd10
  } alu_op_e;

  // branch conditions, same codes as funct3
  // 3'b010 is not a branch funct3, so it marks non-branches
  typedef enum logic [2:0] {
    BR_BEQ  = 3'b000,
    BR_BNE  = 3'b001,
    BR_NONE = 3'b010,
    BR_BLT  = 3'b100,
    BR_BGE  = 3'b101,
    BR_BLTU = 3'b110,
    BR_BGEU = 3'b111
  } branch_op_e;

endpackage

`default_nettype wire

//--- design/rv_decode_if.sv
`timescale 1ns/10ps
`include "rv_settings.svh"
`default_nettype none

// decoded control bundle, decoder to datapath
interface rv_decode_if;

  logic [`RV_REG_ADDR_W-1:0] rs1;
  logic [`RV_REG_ADDR_W-1:0] rs2;
  logic [`RV_REG_ADDR_W-1:0] rd;
  // already sign-extended or shifted into place
  logic [`RV_XLEN-1:0]       imm;
  logic                      use_imm;
  rv_pkg::alu_op_e           alu_op;
  logic                      reg_we;
  rv_pkg::branch_op_e        branch_op;
  logic                      halt;

  modport decoder (
    output rs1, rs2, rd, imm, use_imm, alu_op, reg_we, branch_op, halt
  );

  modport datapath (
    input rs1, rs2, rd, imm, use_imm, alu_op, reg_we, branch_op, halt
  );

endinterface

`default_nettype wire

//--- design/rv_decoder.sv
`timescale 1ns/10ps
`include "rv_settings.svh"
`default_nettype none

module rv_decoder (
  input  wire logic [`RV_XLEN-1:0] i_insn,
  rv_decode_if.decoder             dec
);

  rv_pkg::opcode_e     opcode;
  logic [2:0]          funct3;
  logic [6:0]          funct7;
  logic [`RV_XLEN-1:0] imm_i;
  logic [`RV_XLEN-1:0] imm_b;
  logic [`RV_XLEN-1:0] imm_u;

  // instruction fields
  assign opcode = rv_pkg::opcode_e'(i_insn[6:0]);
  assign funct3 = i_insn[14:12];
  assign funct7 = i_insn[31:25];

  // immediates sign-extended from insn[31]
  assign imm_i = {{20{i_insn[31]}}, i_insn[31:20]};
  assign imm_b = {{20{i_insn[31]}}, i_insn[7], i_insn[30:25], i_insn[11:8], 1'b0};
  // lui value goes into the upper 20 bits
  assign imm_u = {i_insn[31:12], 12'd0};

  always_comb begin
    // register indices come straight from the fixed field positions
    dec.rs1       = i_insn[19:15];
    dec.rs2       = i_insn[24:20];
    dec.rd        = i_insn[11:7];
    dec.imm       = imm_i;
    dec.use_imm   = 1'b0;
    dec.alu_op    = rv_pkg::ALU_ADD;
    dec.reg_we    = 1'b0;
    dec.branch_op = rv_pkg::BR_NONE;
    dec.halt      = 1'b0;

    case (opcode)
      rv_pkg::OPC_LUI: begin
        dec.imm     = imm_u;
        dec.use_imm = 1'b1;
        dec.alu_op  = rv_pkg::ALU_PASS_B;
        dec.reg_we  = 1'b1;
      end

      rv_pkg::OPC_OP_IMM: begin
        dec.use_imm = 1'b1;
        dec.reg_we  = 1'b1;
        case (funct3)
          3'b000: dec.alu_op = rv_pkg::ALU_ADD;
          3'b010: dec.alu_op = rv_pkg::ALU_SLT;
          3'b011: dec.alu_op = rv_pkg::ALU_SLTU;
          3'b100: dec.alu_op = rv_pkg::ALU_XOR;
          3'b110: dec.alu_op = rv_pkg::ALU_OR;
          3'b111: dec.alu_op = rv_pkg::ALU_AND;
          3'b001: begin
            dec.alu_op = rv_pkg::ALU_SLL;
            // slli needs funct7 of zero
            if (funct7 != 7'b0000000) begin
              dec.reg_we = 1'b0;
            end
          end
          default: begin
            // srli or srai only for funct7 of 0000000 or 0100000
            if (funct7 == 7'b0000000) begin
              dec.alu_op = rv_pkg::ALU_SRL;
            end else if (funct7 == 7'b0100000) begin
              dec.alu_op = rv_pkg::ALU_SRA;
            end else begin
              dec.reg_we = 1'b0;
            end
          end
        endcase
      end

      rv_pkg::OPC_OP: begin
        dec.reg_we = 1'b1;
        case ({funct7, funct3})
          {7'b0000000, 3'b000}: dec.alu_op = rv_pkg::ALU_ADD;
          {7'b0100000, 3'b000}: dec.alu_op = rv_pkg::ALU_SUB;
          {7'b0000000, 3'b001}: dec.alu_op = rv_pkg::ALU_SLL;
          {7'b0000000, 3'b010}: dec.alu_op = rv_pkg::ALU_SLT;
          {7'b0000000, 3'b011}: dec.alu_op = rv_pkg::ALU_SLTU;
          {7'b0000000, 3'b100}: dec.alu_op = rv_pkg::ALU_XOR;
          {7'b0000000, 3'b101}: dec.alu_op = rv_pkg::ALU_SRL;
          {7'b0100000, 3'b101}: dec.alu_op = rv_pkg::ALU_SRA;
          {7'b0000000, 3'b110}: dec.alu_op = rv_pkg::ALU_OR;
          {7'b0000000, 3'b111}: dec.alu_op = rv_pkg::ALU_AND;
          // m extension and other funct7 values
          default: dec.reg_we = 1'b0;
        endcase
      end

      rv_pkg::OPC_BRANCH: begin
        dec.imm = imm_b;
        // funct3 010 and 011 stay as BR_NONE
        if (funct3 != 3'b010 && funct3 != 3'b011) begin
          dec.branch_op = rv_pkg::branch_op_e'(funct3);
        end
      end

      rv_pkg::OPC_SYSTEM: begin
        // ecall only when every other bit is zero
        if (i_insn[31:7] == 25'd0) begin
          dec.halt = 1'b1;
        end
      end

      // dropped opcodes and unknown encodings
      default: begin
        dec.reg_we = 1'b0;
      end
    endcase
  end

endmodule

`default_nettype wire

//--- design/rv_regfile.sv
`timescale 1ns/10ps
`include "rv_settings.svh"
`default_nettype none

module rv_regfile (
  input  wire logic                      clk,
  input  wire logic                      rst,
  input  wire logic [`RV_REG_ADDR_W-1:0] i_rs1_addr,
  input  wire logic [`RV_REG_ADDR_W-1:0] i_rs2_addr,
  input  wire logic [`RV_REG_ADDR_W-1:0] i_rd_addr,
  input  wire logic                      i_rd_we,
  input  wire logic [`RV_XLEN-1:0]       i_rd_data,
  output logic      [`RV_XLEN-1:0]       o_rs1_data,
  output logic      [`RV_XLEN-1:0]       o_rs2_data
);

  // x0 has no storage
  logic [`RV_XLEN-1:0] regs [1:`RV_NUM_REGS-1];

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 1; i < `RV_NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (i_rd_we && i_rd_addr != '0) begin
      regs[i_rd_addr] <= i_rd_data;
    end
  end

  // asynchronous reads, index zero reads as 0
  assign o_rs1_data = (i_rs1_addr == '0) ? '0 : regs[i_rs1_addr];
  assign o_rs2_data = (i_rs2_addr == '0) ? '0 : regs[i_rs2_addr];

endmodule

`default_nettype wire

//--- design/rv_alu.sv
`timescale 1ns/10ps
`include "rv_settings.svh"
`default_nettype none

module rv_alu (
  input  rv_pkg::alu_op_e           i_op,
  input  wire logic [`RV_XLEN-1:0]  i_a,
  input  wire logic [`RV_XLEN-1:0]  i_b,
  output logic      [`RV_XLEN-1:0]  o_result
);

  logic [4:0] shamt;
  logic       lt_signed;
  logic       lt_unsigned;

  // shift amount is the low five bits of the second operand
  assign shamt       = i_b[4:0];
  assign lt_signed   = $signed(i_a) < $signed(i_b);
  assign lt_unsigned = i_a < i_b;

  always_comb begin
    case (i_op)
      rv_pkg::ALU_ADD: begin
        o_result = i_a + i_b;
      end
      rv_pkg::ALU_SUB: begin
        o_result = i_a - i_b;
      end
      rv_pkg::ALU_SLL: begin
        o_result = i_a << shamt;
      end
      rv_pkg::ALU_SLT: begin
        o_result = {{(`RV_XLEN-1){1'b0}}, lt_signed};
      end
      rv_pkg::ALU_SLTU: begin
        o_result = {{(`RV_XLEN-1){1'b0}}, lt_unsigned};
      end
      rv_pkg::ALU_XOR: begin
        o_result = i_a ^ i_b;
      end
      rv_pkg::ALU_SRL: begin
        o_result = i_a >> shamt;
      end
      rv_pkg::ALU_SRA: begin
        // arithmetic shift keeps the sign bit
        o_result = $unsigned($signed(i_a) >>> shamt);
      end
      rv_pkg::ALU_OR: begin
        o_result = i_a | i_b;
      end
      rv_pkg::ALU_AND: begin
        o_result = i_a & i_b;
      end
      rv_pkg::ALU_PASS_B: begin
        o_result = i_b;
      end
      default: begin
        o_result = '0;
      end
    endcase
  end

endmodule

`default_nettype wire

//--- design/rv_pc_unit.sv
`timescale 1ns/10ps
`include "rv_settings.svh"
`default_nettype none

module rv_pc_unit (
  input  wire logic                clk,
  input  wire logic                rst,
  input  wire logic [`RV_XLEN-1:0] i_rs1_data,
  input  wire logic [`RV_XLEN-1:0] i_rs2_data,
  rv_decode_if.datapath            dec,
  output logic      [`RV_XLEN-1:0] o_pc
);

  logic [`RV_XLEN-1:0] pc_q;
  logic [`RV_XLEN-1:0] pc_next;
  logic                taken;

  // branch condition
  always_comb begin
    case (dec.branch_op)
      rv_pkg::BR_BEQ:  taken = (i_rs1_data == i_rs2_data);
      rv_pkg::BR_BNE:  taken = (i_rs1_data != i_rs2_data);
      rv_pkg::BR_BLT:  taken = ($signed(i_rs1_data) < $signed(i_rs2_data));
      rv_pkg::BR_BGE:  taken = ($signed(i_rs1_data) >= $signed(i_rs2_data));
      rv_pkg::BR_BLTU: taken = (i_rs1_data < i_rs2_data);
      rv_pkg::BR_BGEU: taken = (i_rs1_data >= i_rs2_data);
      default:         taken = 1'b0;
    endcase
  end

  // next pc, ecall parks the core on the current pc
  always_comb begin
    if (taken) begin
      pc_next = pc_q + dec.imm;
    end else if (dec.halt) begin
      pc_next = pc_q;
    end else begin
      pc_next = pc_q + `RV_XLEN'(`RV_INSN_BYTES);
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      pc_q <= `RV_RESET_PC;
    end else begin
      pc_q <= pc_next;
    end
  end

  assign o_pc = pc_q;

endmodule

`default_nettype wire

//--- design/rv_core.sv
`timescale 1ns/10ps
`include "rv_settings.svh"
`default_nettype none

module rv_core (
  input  wire logic                      clk,
  input  wire logic                      rst,
  input  wire logic [`RV_XLEN-1:0]       i_insn,
  output logic      [`RV_XLEN-1:0]       o_pc,
  output logic                           o_halt,
  output logic                           o_wb_valid,
  output logic      [`RV_REG_ADDR_W-1:0] o_wb_rd,
  output logic      [`RV_XLEN-1:0]       o_wb_data
);

  rv_decode_if dec_if ();

  logic [`RV_XLEN-1:0] rs1_data;
  logic [`RV_XLEN-1:0] rs2_data;
  logic [`RV_XLEN-1:0] alu_b;
  logic [`RV_XLEN-1:0] alu_result;
  logic                wb_valid;

  rv_decoder decoder_inst (
    .i_insn (i_insn),
    .dec    (dec_if.decoder)
  );

  // write only outside reset and never to x0
  assign wb_valid = !rst && dec_if.reg_we && (dec_if.rd != '0);

  rv_regfile regfile_inst (
    .clk        (clk),
    .rst        (rst),
    .i_rs1_addr (dec_if.rs1),
    .i_rs2_addr (dec_if.rs2),
    .i_rd_addr  (dec_if.rd),
    .i_rd_we    (wb_valid),
    .i_rd_data  (alu_result),
    .o_rs1_data (rs1_data),
    .o_rs2_data (rs2_data)
  );

  // second operand, immediate or rs2
  assign alu_b = dec_if.use_imm ? dec_if.imm : rs2_data;

  rv_alu alu_inst (
    .i_op     (dec_if.alu_op),
    .i_a      (rs1_data),
    .i_b      (alu_b),
    .o_result (alu_result)
  );

  rv_pc_unit pc_unit_inst (
    .clk        (clk),
    .rst        (rst),
    .i_rs1_data (rs1_data),
    .i_rs2_data (rs2_data),
    .dec        (dec_if.datapath),
    .o_pc       (o_pc)
  );

  // retirement trace, zero unless a write retires
  assign o_wb_valid = wb_valid;
  assign o_wb_rd    = wb_valid ? dec_if.rd : '0;
  assign o_wb_data  = wb_valid ? alu_result : '0;
  assign o_halt     = !rst && dec_if.halt;

endmodule

`default_nettype wire

//--- testbench/rv_core_asserts.sv
`timescale 1ns/10ps
`include "rv_settings.svh"
`default_nettype none

module rv_core_asserts (
  input wire logic                      clk,
  input wire logic                      rst,
  input wire logic [`RV_XLEN-1:0]       i_pc,
  input wire logic                      i_halt,
  input wire logic                      i_wb_valid,
  input wire logic [`RV_REG_ADDR_W-1:0] i_wb_rd
);

  // a retired write never names x0
  wb_rd_nonzero: assert property (@(posedge clk) i_wb_valid |-> (i_wb_rd != '0))
    else $error("write trace reports x0 as destination");

  pc_aligned: assert property (@(posedge clk) disable iff (rst) (i_pc[1:0] == 2'b00))
    else $error("pc is not word aligned");

  // ecall parks the pc
  halt_holds_pc: assert property (@(posedge clk) disable iff (rst) i_halt |=> $stable(i_pc))
    else $error("pc moved after a halt cycle");

  reset_quiet: assert property (@(posedge clk) rst |-> (!i_wb_valid && !i_halt))
    else $error("trace outputs active during reset");

endmodule

bind rv_core rv_core_asserts asserts_inst (
  .clk        (clk),
  .rst        (rst),
  .i_pc       (o_pc),
  .i_halt     (o_halt),
  .i_wb_valid (o_wb_valid),
  .i_wb_rd    (o_wb_rd)
);

`default_nettype wire

//--- testbench/rv_core_tb.sv
`timescale 1ns/10ps
`include "rv_settings.svh"
`default_nettype none

module rv_core_tb;

  localparam int MEM_WORDS  = 64;
  // sum of all program lengths with margin
  localparam int MAX_CYCLES = 4000;

  localparam logic [6:0]  OPC_LUI    = 7'b0110111;
  localparam logic [6:0]  OPC_OP_IMM = 7'b0010011;
  localparam logic [6:0]  OPC_OP     = 7'b0110011;
  localparam logic [6:0]  OPC_BRANCH = 7'b1100011;
  localparam logic [6:0]  OPC_SYSTEM = 7'b1110011;
  localparam logic [31:0] ECALL      = 32'h0000_0073;

  logic                      clk;
  logic                      rst;
  logic [`RV_XLEN-1:0]       insn;
  logic [`RV_XLEN-1:0]       pc;
  logic                      halt;
  logic                      wb_valid;
  logic [`RV_REG_ADDR_W-1:0] wb_rd;
  logic [`RV_XLEN-1:0]       wb_data;

  logic [31:0] imem [0:MEM_WORDS-1];
  logic [31:0] model_regs [0:`RV_NUM_REGS-1];
  logic [31:0] rng;
  int          prog_len;
  int          errors;
  int          checks;
  int          cycles = 0;

  rv_core rv_core_inst (
    .clk        (clk),
    .rst        (rst),
    .i_insn     (insn),
    .o_pc       (pc),
    .o_halt     (halt),
    .o_wb_valid (wb_valid),
    .o_wb_rd    (wb_rd),
    .o_wb_data  (wb_data)
  );

  // combinational fetch from the pc
  // an unknown or out-of-range pc reads ecall
  assign insn = (pc[31:8] === '0) ? imem[pc[7:2]] : ECALL;

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= MAX_CYCLES) begin
      $display("timeout: the run did not finish within %0d cycles", MAX_CYCLES);
      $display("SOME TESTS FAILED");
      $finish;
    end
  end

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function automatic logic [31:0] fetch_word(input logic [31:0] addr);
    return (addr[31:8] == '0) ? imem[addr[7:2]] : ECALL;
  endfunction

  // instruction encoders
  function automatic logic [31:0] enc_r(input int f7, input int rs2, input int rs1,
                                        input int f3, input int rd);
    return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], OPC_OP};
  endfunction

  function automatic logic [31:0] enc_i(input logic [6:0] opc, input int rd, input int f3,
                                        input int rs1, input int imm);
    return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], opc};
  endfunction

  function automatic logic [31:0] enc_u(input int rd, input int imm);
    return {imm[19:0], rd[4:0], OPC_LUI};
  endfunction

  function automatic logic [31:0] enc_b(input int f3, input int rs1, input int rs2,
                                        input int off);
    return {off[12], off[10:5], rs2[4:0], rs1[4:0], f3[2:0], off[4:1], off[11], OPC_BRANCH};
  endfunction

  // reference alu selected by funct3 and the alternate bit 30
  function automatic logic [31:0] alu_rule(input logic [2:0] f3, input logic alt,
                                           input logic [31:0] a, input logic [31:0] b);
    logic [4:0] sh;
    sh = b[4:0];
    case (f3)
      3'd0:    return alt ? a - b : a + b;
      3'd1:    return a << sh;
      3'd2:    return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      3'd3:    return (a < b) ? 32'd1 : 32'd0;
      3'd4:    return a ^ b;
      // copies of the sign bit fill the vacated upper bits
      3'd5:    return alt ? (a >> sh) | (~(32'hffff_ffff >> sh) & {32{a[31]}}) : a >> sh;
      3'd6:    return a | b;
      default: return a & b;
    endcase
  endfunction

  function automatic logic branch_taken(input logic [2:0] f3, input logic [31:0] a,
                                        input logic [31:0] b);
    case (f3)
      3'd0:    return a == b;
      3'd1:    return a != b;
      3'd4:    return $signed(a) < $signed(b);
      3'd5:    return $signed(a) >= $signed(b);
      3'd6:    return a < b;
      3'd7:    return a >= b;
      default: return 1'b0;
    endcase
  endfunction

  // one instruction of the reference model
  task automatic model_step(input logic [31:0] word, input logic [31:0] cur_pc,
                            output logic we, output logic [4:0] rd, output logic [31:0] data,
                            output logic stop, output logic [31:0] next_pc);
    logic [6:0]  f7;
    logic [2:0]  f3;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] imm_i;
    logic [31:0] imm_b;
    f7 = word[31:25];
    f3 = word[14:12];
    rd = word[11:7];
    a = model_regs[word[19:15]];
    b = model_regs[word[24:20]];
    imm_i = {{20{word[31]}}, word[31:20]};
    imm_b = {{20{word[31]}}, word[7], word[30:25], word[11:8], 1'b0};
    we = 1'b0;
    data = '0;
    stop = 1'b0;
    next_pc = cur_pc + 32'd4;
    case (word[6:0])
      OPC_LUI: begin
        we = 1'b1;
        data = {word[31:12], 12'd0};
      end
      OPC_OP_IMM: begin
        if (f3 == 3'd1) begin
          we = (f7 == 7'h00);
        end else if (f3 == 3'd5) begin
          we = (f7 == 7'h00) || (f7 == 7'h20);
        end else begin
          we = 1'b1;
        end
        // bit 30 only modifies the right shift here
        data = alu_rule(f3, (f3 == 3'd5) && word[30], a, imm_i);
      end
      OPC_OP: begin
        we = (f7 == 7'h00) || ((f7 == 7'h20) && ((f3 == 3'd0) || (f3 == 3'd5)));
        data = alu_rule(f3, word[30], a, b);
      end
      OPC_BRANCH: begin
        if (branch_taken(f3, a, b)) begin
          next_pc = cur_pc + imm_b;
        end
      end
      OPC_SYSTEM: begin
        if (word[31:7] == '0) begin
          stop = 1'b1;
          next_pc = cur_pc;
        end
      end
      default: begin
        we = 1'b0;
      end
    endcase
    if (rd == 5'd0) begin
      we = 1'b0;
    end
  endtask

  task automatic check_value(input string what, input logic [31:0] got,
                             input logic [31:0] exp);
    checks++;
    assert (got === exp) else begin
      errors++;
      $display("Fail at %0t ns: %s is %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic emit(input logic [31:0] word);
    if (prog_len < MEM_WORDS) begin
      imem[prog_len[5:0]] = word;
      prog_len++;
    end else begin
      errors++;
      $display("program is longer than the instruction memory");
    end
  endtask

  // lui plus addi with the upper part rounded for the signed low half
  task automatic load_const(input int rd, input logic [31:0] value);
    logic [31:0] upper;
    upper = value + 32'h800;
    emit(enc_u(rd, upper >> 12));
    emit(enc_i(OPC_OP_IMM, rd, 0, rd, value));
  endtask

  // reset goes high here and the old program is wiped
  task automatic begin_program();
    @(posedge clk);
    rst <= 1'b1;
    for (int i = 0; i < MEM_WORDS; i++) begin
      imem[i[5:0]] = ECALL;
    end
    prog_len = 0;
  endtask

  task automatic run_program(input string name, input int hold);
    logic [31:0] pc_exp;
    logic [31:0] word;
    logic [31:0] data;
    logic [31:0] next_pc;
    logic [4:0]  rd;
    logic        we;
    logic        stop;
    int          halted;
    int          steps;
    halted = 0;
    steps = 0;
    pc_exp = `RV_RESET_PC;
    for (int i = 0; i < `RV_NUM_REGS; i++) begin
      model_regs[i[4:0]] = '0;
    end
    repeat (3) begin
      @(negedge clk);
      check_value({name, ": o_wb_valid in reset"}, {31'd0, wb_valid}, 32'd0);
      check_value({name, ": o_halt in reset"}, {31'd0, halt}, 32'd0);
      @(posedge clk);
    end
    rst <= 1'b0;
    while (halted < hold && steps < 4 * MEM_WORDS) begin
      @(negedge clk);
      word = fetch_word(pc_exp);
      model_step(word, pc_exp, we, rd, data, stop, next_pc);
      check_value({name, ": o_pc"}, pc, pc_exp);
      check_value({name, ": o_halt"}, {31'd0, halt}, {31'd0, stop});
      check_value({name, ": o_wb_valid"}, {31'd0, wb_valid}, {31'd0, we});
      if (we) begin
        check_value({name, ": o_wb_rd"}, {27'd0, wb_rd}, {27'd0, rd});
        check_value({name, ": o_wb_data"}, wb_data, data);
        model_regs[rd] = data;
      end
      if (stop) begin
        halted++;
      end
      pc_exp = next_pc;
      steps++;
    end
    assert (halted > 0) else begin
      errors++;
      $display("%s: program never reached its ecall", name);
    end
  endtask

  task automatic test_sequence();
    begin_program();
    for (int i = 1; i <= 6; i++) begin
      emit(enc_i(OPC_OP_IMM, i, 0, i - 1, 3 * i));
    end
    emit(ECALL);
    run_program("sequence", 4);
  endtask

  task automatic test_imm_ops();
    int f3s [0:5] = '{0, 2, 3, 4, 6, 7};
    begin_program();
    for (int round = 0; round < 3; round++) begin
      rng = xorshift32(rng);
      load_const(5, rng);
      rng = xorshift32(rng);
      emit(enc_u(6, rng));
      for (int j = 0; j < 6; j++) begin
        rng = xorshift32(rng);
        emit(enc_i(OPC_OP_IMM, 10 + j, f3s[j[2:0]], 5 + (j % 2), rng));
      end
      rng = xorshift32(rng);
      emit(enc_i(OPC_OP_IMM, 16, 1, 5, rng & 32'd31));
      emit(enc_i(OPC_OP_IMM, 17, 5, 6, rng & 32'd31));
      // funct7 0100000 selects the arithmetic shift
      emit(enc_i(OPC_OP_IMM, 18, 5, 6, 32'h400 | (rng & 32'd31)));
    end
    emit(ECALL);
    run_program("op-imm", 4);
  endtask

  task automatic test_reg_ops();
    int f7s [0:9] = '{0, 32, 0, 0, 0, 0, 0, 32, 0, 0};
    int f3s [0:9] = '{0, 0, 1, 2, 3, 4, 5, 5, 6, 7};
    begin_program();
    for (int round = 0; round < 2; round++) begin
      rng = xorshift32(rng);
      load_const(1, rng);
      rng = xorshift32(rng);
      load_const(2, rng);
      rng = xorshift32(rng);
      load_const(3, rng | 32'h8000_0000);
      rng = xorshift32(rng);
      load_const(4, rng & 32'h7fff_ffff);
      for (int j = 0; j < 10; j++) begin
        emit(enc_r(f7s[j[3:0]], 2, 1, f3s[j[3:0]], 10 + j));
      end
      // operands of opposite sign
      emit(enc_r(0, 4, 3, 2, 20));
      emit(enc_r(0, 3, 4, 2, 21));
      emit(enc_r(0, 4, 3, 3, 22));
      emit(enc_r(0, 3, 4, 3, 23));
      emit(enc_r(32, 2, 3, 5, 24));
    end
    emit(ECALL);
    run_program("op", 4);
  endtask

  // the first branch is taken and skips its marker while the second falls through
  task automatic branch_pair(input int f3, input int ta, input int tb, input int na,
                             input int nb);
    emit(enc_b(f3, ta, tb, 8));
    emit(enc_i(OPC_OP_IMM, 30, 0, 30, 1));
    emit(enc_b(f3, na, nb, 8));
    emit(enc_i(OPC_OP_IMM, 30, 0, 30, 1));
  endtask

  task automatic test_branches();
    begin_program();
    load_const(1, 32'hffff_fffd);
    load_const(2, 32'd7);
    load_const(3, 32'd7);
    branch_pair(0, 2, 3, 1, 2);
    branch_pair(1, 1, 2, 2, 3);
    branch_pair(4, 1, 2, 2, 1);
    branch_pair(5, 2, 1, 1, 2);
    branch_pair(6, 2, 1, 1, 2);
    branch_pair(7, 1, 2, 2, 1);
    // countdown loop closed by a backward bne
    emit(enc_i(OPC_OP_IMM, 20, 0, 0, 3));
    emit(enc_i(OPC_OP_IMM, 20, 0, 20, -1));
    emit(enc_b(1, 20, 0, -4));
    emit(ECALL);
    run_program("branch", 4);
  endtask

  task automatic test_x0_and_illegal();
    begin_program();
    load_const(8, 32'h1234_5678);
    emit(enc_i(OPC_OP_IMM, 0, 0, 8, 123));
    emit(enc_r(0, 0, 0, 0, 9));
    // mul, lw, slli with bad funct7, jal, auipc, ebreak, all zero
    emit(enc_r(1, 8, 8, 0, 11));
    emit(enc_i(7'b0000011, 12, 2, 8, 0));
    emit(enc_i(OPC_OP_IMM, 13, 1, 8, 32'h403));
    emit(32'h0000_076f);
    emit(32'h0000_0717);
    emit(32'h0010_0073);
    emit(32'h0000_0000);
    emit(enc_r(0, 8, 0, 0, 15));
    emit(ECALL);
    run_program("x0-illegal", 4);
  endtask

  task automatic test_halt();
    begin_program();
    emit(enc_i(OPC_OP_IMM, 1, 0, 0, 42));
    emit(ECALL);
    emit(enc_i(OPC_OP_IMM, 2, 0, 0, 43));
    run_program("halt", 12);
  endtask

  initial begin
    rst = 1'b1;
    errors = 0;
    checks = 0;
    prog_len = 0;
    rng = 32'd74933;
    for (int i = 0; i < MEM_WORDS; i++) begin
      imem[i[5:0]] = ECALL;
    end
    test_sequence();
    test_imm_ops();
    test_reg_ops();
    test_branches();
    test_x0_and_illegal();
    test_halt();
    $display("checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- tb.f
+incdir+design
design/rv_pkg.sv
design/rv_decode_if.sv
design/rv_decoder.sv
design/rv_regfile.sv
design/rv_alu.sv
design/rv_pc_unit.sv
design/rv_core.sv
testbench/rv_core_asserts.sv
testbench/rv_core_tb.sv

//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = rv_core_tb
FILELIST  = tb.f
OBJ_DIR   = obj_dir

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) | tee /dev/stderr | grep -q "ALL TESTS PASSED"

clean:
	rm -rf $(OBJ_DIR)
